// File: src/eth_pkg.sv
// Ethernet framing constants with byte, address, length and CRC types
package eth_pkg;

    // ----------------------------------------
    // Types
    // ----------------------------------------
    typedef logic [7:0]  byte_t;        // One octet on the GMII bus
    typedef logic [47:0] mac_addr_t;
    typedef logic [15:0] len_t;         // Payload and IP length counts
    typedef logic [31:0] crc_t;

    // ----------------------------------------
    // Framing constants
    // ----------------------------------------

    // Seven preamble bytes followed by the SFD
    localparam int    PREAMBLE_LEN  = 8;
    localparam byte_t PREAMBLE_BYTE = 8'h55;
    localparam byte_t SFD_BYTE      = 8'hd5;

    // Destination, source and ethertype
    localparam int          ETH_HDR_LEN   = 14;
    localparam logic [15:0] ETH_TYPE_IPV4 = 16'h0800;

    // 46-byte minimum payload minus the 28 header bytes
    localparam int MIN_PAYLOAD = 18;

    localparam int FCS_LEN = 4;         // CRC-32 trailer

endpackage

// File: src/icmp_pkg.sv
// IPv4 and ICMP header field constants with header word and checksum types
package icmp_pkg;

    // ----------------------------------------
    // Types
    // ----------------------------------------
    typedef logic [31:0] ip_addr_t;
    typedef logic [31:0] hdr_word_t;    // Sent most significant byte first
    typedef logic [15:0] csum_t;        // Finished ones' complement checksum
    typedef logic [31:0] csum_acc_t;    // Sum before the carries are folded

    // ----------------------------------------
    // Header layout
    // ----------------------------------------

    // Five IPv4 words then two ICMP words
    localparam int HDR_WORDS       = 7;
    localparam int IP_ICMP_HDR_LEN = 28;

    // Fixed field values
    localparam logic [7:0]  IP_VER_IHL      = 8'h45;    // Version 4, five words
    localparam logic [7:0]  IP_TTL          = 8'h80;
    localparam logic [7:0]  IP_PROTO_ICMP   = 8'h01;
    localparam logic [15:0] IP_FLAGS_DF     = 16'h4000; // Don't fragment, offset 0
    localparam logic [7:0]  ICMP_ECHO_REPLY = 8'h00;

endpackage

// File: src/icmp_hdr_if.sv
// Finished header set passed from the header builder to the frame sender
interface icmp_hdr_if import eth_pkg::*, icmp_pkg::*; ();

    logic      hdr_valid;               // Single-cycle, only while frame_busy is low
    hdr_word_t hdr_words [HDR_WORDS];   // Words 0 to 4 IPv4, 5 and 6 ICMP
    mac_addr_t dst_mac;
    len_t      payload_len;
    logic      frame_busy;              // Set after capture, cleared after the FCS

    modport builder (
        output hdr_valid,
        output hdr_words,
        output dst_mac,
        output payload_len,
        input  frame_busy
    );

    modport sender (
        input  hdr_valid,
        input  hdr_words,
        input  dst_mac,
        input  payload_len,
        output frame_busy
    );

endinterface

// File: src/eth_crc32.sv
// Byte-wide reflected Ethernet CRC-32 with FCS byte selection
module eth_crc32 import eth_pkg::*; (
    input  logic       clk,
    input  logic       rst_n,
    input  logic       crc_clr,         // Restart from all ones
    input  logic       crc_en,
    input  byte_t      crc_din,
    input  logic [1:0] fcs_idx,         // 0 is sent first
    output byte_t      fcs_byte
);

    localparam crc_t POLY = 32'hedb8_8320;  // 0x04c11db7 bit-reversed

    crc_t crc;

    // Eight bit steps, LSB of the byte first
    function automatic crc_t crc_step(input crc_t c, input byte_t d);
        crc_t r;
        r = c ^ crc_t'(d);
        for (int i = 0; i < 8; i++) begin
            r = r[0] ? ((r >> 1) ^ POLY) : (r >> 1);
        end
        return r;
    endfunction

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            crc <= '1;
        end else if (crc_clr) begin
            crc <= '1;
        end else if (crc_en) begin
            crc <= crc_step(crc, crc_din);
        end
    end

    assign fcs_byte = ~crc[8 * fcs_idx +: 8];

endmodule

// File: src/icmp_hdr_build.sv
// Request latch, IP identification counter and checksum pipeline
module icmp_hdr_build import eth_pkg::*, icmp_pkg::*; #(
    parameter ip_addr_t board_ip = {8'd192, 8'd168, 8'd1, 8'd123}
) (
    input  logic        clk,
    input  logic        rst_n,
    input  logic        tx_start,
    input  mac_addr_t   dst_mac,
    input  ip_addr_t    dst_ip,
    input  logic [15:0] icmp_id,
    input  logic [15:0] icmp_seq,
    input  len_t        payload_len,
    input  csum_acc_t   payload_sum,    // Sum of the payload's 16-bit words
    output logic        busy,
    icmp_hdr_if.builder hdr
);

    logic        accept;
    logic        pending;               // Request taken, sender not yet busy
    logic [3:0]  stage;                 // Sum, fold, fold, invert
    logic [15:0] ip_ident;

    // Latched request
    mac_addr_t   req_mac;
    ip_addr_t    req_ip;
    logic [15:0] req_id;
    logic [15:0] req_seq;
    len_t        req_len;
    csum_acc_t   req_sum;
    len_t        total_len;

    csum_acc_t   ip_acc;
    csum_acc_t   icmp_acc;
    csum_t       ip_csum;
    csum_t       icmp_csum;

    function automatic csum_acc_t wide(input logic [15:0] v);
        return csum_acc_t'(v);
    endfunction

    // Carries wrap back into the low half
    function automatic csum_acc_t fold(input csum_acc_t v);
        return wide(v[31:16]) + wide(v[15:0]);
    endfunction

    assign accept    = tx_start && !busy;
    assign busy      = pending || hdr.frame_busy;
    assign total_len = req_len + len_t'(IP_ICMP_HDR_LEN);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pending       <= 1'b0;
            stage         <= '0;
            ip_ident      <= '0;
            hdr.hdr_valid <= 1'b0;
        end else begin
            stage         <= {stage[2:0], accept};
            hdr.hdr_valid <= stage[3];
            if (accept) begin
                pending  <= 1'b1;
                ip_ident <= ip_ident + 16'd1;   // First frame carries 1
            end else if (hdr.hdr_valid) begin
                pending <= 1'b0;                // Sender takes over busy
            end
        end
    end

    // ----------------------------------------
    // Checksum datapath
    // ----------------------------------------
    always_ff @(posedge clk) begin
        if (accept) begin
            req_mac <= dst_mac;
            req_ip  <= dst_ip;
            req_id  <= icmp_id;
            req_seq <= icmp_seq;
            req_len <= payload_len;
            req_sum <= payload_sum;
        end
        if (stage[0]) begin
            // Checksum field counts as zero
            ip_acc <= wide({IP_VER_IHL, 8'h00}) + wide(total_len) + wide(ip_ident)
                    + wide(IP_FLAGS_DF) + wide({IP_TTL, IP_PROTO_ICMP})
                    + wide(board_ip[31:16]) + wide(board_ip[15:0])
                    + wide(req_ip[31:16]) + wide(req_ip[15:0]);
            icmp_acc <= wide({ICMP_ECHO_REPLY, 8'h00}) + wide(req_id) + wide(req_seq)
                      + req_sum;
        end
        if (stage[1] || stage[2]) begin
            ip_acc   <= fold(ip_acc);
            icmp_acc <= fold(icmp_acc);
        end
        if (stage[3]) begin
            ip_csum   <= ~ip_acc[15:0];
            icmp_csum <= ~icmp_acc[15:0];
        end
    end

    always_comb begin
        hdr.hdr_words[0] = {IP_VER_IHL, 8'h00, total_len};
        hdr.hdr_words[1] = {ip_ident, IP_FLAGS_DF};
        hdr.hdr_words[2] = {IP_TTL, IP_PROTO_ICMP, ip_csum};
        hdr.hdr_words[3] = board_ip;
        hdr.hdr_words[4] = req_ip;
        hdr.hdr_words[5] = {ICMP_ECHO_REPLY, 8'h00, icmp_csum};
        hdr.hdr_words[6] = {req_id, req_seq};
    end

    assign hdr.dst_mac     = req_mac;
    assign hdr.payload_len = req_len;

    a_len_nonzero: assert property (@(posedge clk) disable iff (!rst_n)
        accept |-> payload_len != '0);

    // Sender must be free whenever a header set is offered
    a_valid_free: assert property (@(posedge clk) disable iff (!rst_n)
        hdr.hdr_valid |-> !hdr.frame_busy);

endmodule

// File: src/eth_frame_tx.sv
// Frame FSM and GMII byte serializer with zero padding and FCS
module eth_frame_tx import eth_pkg::*, icmp_pkg::*; #(
    parameter mac_addr_t board_mac = 48'h00_11_22_33_44_55
) (
    input  logic       clk,
    input  logic       rst_n,
    input  byte_t      payload_data,    // One cycle after payload_req
    output logic       payload_req,
    output logic       gmii_tx_en,
    output byte_t      gmii_txd,
    output logic       tx_done,
    icmp_hdr_if.sender hdr
);

    typedef enum logic [2:0] {
        st_idle,
        st_preamble,
        st_eth_head,
        st_ip_head,
        st_payload,
        st_pad,
        st_fcs
    } tx_state_t;

    tx_state_t state;
    tx_state_t next_state;
    len_t      cnt;                     // Byte index inside the current state
    len_t      last_cnt;
    byte_t     tx_byte;
    hdr_word_t cur_word;
    logic      frame_end;
    logic      crc_clr;
    logic      crc_en;
    byte_t     fcs_byte;

    // Captured header set
    hdr_word_t words [HDR_WORDS];
    mac_addr_t dst_mac;
    len_t      pay_len;

    logic [ETH_HDR_LEN*8-1:0] eth_hdr;

    assign eth_hdr  = {dst_mac, board_mac, ETH_TYPE_IPV4};
    assign cur_word = words[cnt[4:2]];

    // Byte for the next GMII cycle and where the state ends
    always_comb begin
        tx_byte    = '0;
        last_cnt   = '0;
        next_state = st_idle;
        case (state)
            st_preamble: begin
                tx_byte    = (cnt == len_t'(PREAMBLE_LEN - 1)) ? SFD_BYTE : PREAMBLE_BYTE;
                last_cnt   = len_t'(PREAMBLE_LEN - 1);
                next_state = st_eth_head;
            end
            st_eth_head: begin
                tx_byte    = eth_hdr[8 * (ETH_HDR_LEN - 1 - int'(cnt[3:0])) +: 8];
                last_cnt   = len_t'(ETH_HDR_LEN - 1);
                next_state = st_ip_head;
            end
            st_ip_head: begin
                tx_byte    = cur_word[8 * (3 - int'(cnt[1:0])) +: 8]; // MSB first
                last_cnt   = len_t'(IP_ICMP_HDR_LEN - 1);
                next_state = st_payload;
            end
            st_payload: begin
                tx_byte    = payload_data;
                last_cnt   = pay_len - 16'd1;
                next_state = (pay_len < len_t'(MIN_PAYLOAD)) ? st_pad : st_fcs;
            end
            st_pad: begin
                last_cnt   = len_t'(MIN_PAYLOAD - 1);  // Count runs on from payload
                next_state = st_fcs;
            end
            st_fcs: begin
                tx_byte    = fcs_byte;
                last_cnt   = len_t'(FCS_LEN - 1);
                next_state = st_idle;
            end
            default: ;
        endcase
    end

    // Request runs one cycle ahead of each payload slot
    assign payload_req = (state == st_ip_head && cnt == len_t'(IP_ICMP_HDR_LEN - 1))
                      || (state == st_payload && cnt < pay_len - 16'd1);

    assign frame_end = (state == st_idle) && gmii_tx_en;   // Last FCS byte just left
    assign crc_clr   = (state == st_preamble);
    assign crc_en    = state inside {st_eth_head, st_ip_head, st_payload, st_pad};

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state          <= st_idle;
            cnt            <= '0;
            hdr.frame_busy <= 1'b0;
            gmii_tx_en     <= 1'b0;
            gmii_txd       <= '0;
            tx_done        <= 1'b0;
        end else begin
            gmii_tx_en <= (state != st_idle);
            gmii_txd   <= tx_byte;
            tx_done    <= frame_end;
            if (hdr.hdr_valid) begin
                hdr.frame_busy <= 1'b1;
            end else if (frame_end) begin
                hdr.frame_busy <= 1'b0;
            end

            if (state == st_idle) begin
                cnt <= '0;
                if (hdr.hdr_valid) begin
                    state <= st_preamble;
                end
            end else if (cnt == last_cnt) begin
                cnt   <= (next_state == st_pad) ? cnt + 16'd1 : '0;
                state <= next_state;
            end else begin
                cnt <= cnt + 16'd1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (state == st_idle && hdr.hdr_valid) begin
            words   <= hdr.hdr_words;
            dst_mac <= hdr.dst_mac;
            pay_len <= hdr.payload_len;
        end
    end

    eth_crc32 crc0 (
        .clk      (clk),
        .rst_n    (rst_n),
        .crc_clr  (crc_clr),
        .crc_en   (crc_en),
        .crc_din  (tx_byte),
        .fcs_idx  (cnt[1:0]),
        .fcs_byte (fcs_byte)
    );

    // No gap in the burst, it only ends after the fourth FCS byte
    a_burst_whole: assert property (@(posedge clk) disable iff (!rst_n)
        $fell(gmii_tx_en) |-> $past(state == st_fcs && cnt == len_t'(FCS_LEN - 1), 2));

endmodule

// File: src/icmp_reply_tx.sv
// ICMP echo-reply transmitter top level, header builder plus frame sender
module icmp_reply_tx import eth_pkg::*, icmp_pkg::*; #(
    parameter mac_addr_t board_mac = 48'h00_11_22_33_44_55,
    parameter ip_addr_t  board_ip  = {8'd192, 8'd168, 8'd1, 8'd123}
) (
    input  logic        clk,
    input  logic        rst_n,
    input  logic        tx_start,       // Single-cycle request
    input  mac_addr_t   dst_mac,
    input  ip_addr_t    dst_ip,
    input  logic [15:0] icmp_id,
    input  logic [15:0] icmp_seq,
    input  len_t        payload_len,
    input  csum_acc_t   payload_sum,
    output logic        payload_req,
    input  byte_t       payload_data,
    output logic        busy,
    output logic        tx_done,
    output logic        gmii_tx_en,
    output byte_t       gmii_txd
);

    icmp_hdr_if hdr_if0 ();

    icmp_hdr_build #(.board_ip(board_ip)) build0 (
        .clk         (clk),
        .rst_n       (rst_n),
        .tx_start    (tx_start),
        .dst_mac     (dst_mac),
        .dst_ip      (dst_ip),
        .icmp_id     (icmp_id),
        .icmp_seq    (icmp_seq),
        .payload_len (payload_len),
        .payload_sum (payload_sum),
        .busy        (busy),
        .hdr         (hdr_if0.builder)
    );

    eth_frame_tx #(.board_mac(board_mac)) frame0 (
        .clk          (clk),
        .rst_n        (rst_n),
        .payload_data (payload_data),
        .payload_req  (payload_req),
        .gmii_tx_en   (gmii_tx_en),
        .gmii_txd     (gmii_txd),
        .tx_done      (tx_done),
        .hdr          (hdr_if0.sender)
    );

endmodule

// File: dv/icmp_ref.svh
// Reference model with the checksums, the CRC and the expected bytes of one reply frame
`ifndef ICMP_REF_SVH
`define ICMP_REF_SVH

typedef byte_t byte_q_t [$];

// Ones' complement sum of 16-bit words with an odd last byte padded low
function automatic csum_t ones_csum(input byte_q_t b);
    logic [31:0] s;
    s = '0;
    for (int i = 0; i < b.size(); i += 2) begin
        s = s + {16'h0000, b[i], (i + 1 < b.size()) ? b[i + 1] : 8'h00};
    end
    while (s[31:16] != 16'h0000) begin
        s = {16'h0000, s[15:0]} + {16'h0000, s[31:16]};   // End-around carry
    end
    return ~s[15:0];
endfunction

// Reflected CRC-32 one bit at a time, giving the inverted remainder
function automatic crc_t frame_crc(input byte_q_t b, input int first);
    crc_t c;
    logic fb;
    c = '1;
    for (int i = first; i < b.size(); i++) begin
        for (int j = 0; j < 8; j++) begin
            fb = c[0] ^ b[i][j];
            c  = c >> 1;
            if (fb) begin
                c = c ^ 32'hedb8_8320;
            end
        end
    end
    return ~c;
endfunction

function automatic byte_q_t expected_frame(input mac_addr_t dmac, input ip_addr_t dip,
                                           input logic [15:0] id, input logic [15:0] seq,
                                           input logic [15:0] ident, input byte_q_t pay);
    byte_q_t      f;
    byte_q_t      ip;
    byte_q_t      ic;
    logic [159:0] iph;
    logic [63:0]  ich;
    csum_t        c;
    crc_t         fcs;
    len_t         tl;
    tl  = len_t'(pay.size() + IP_ICMP_HDR_LEN);
    iph = {IP_VER_IHL, 8'h00, tl, ident, IP_FLAGS_DF, IP_TTL, IP_PROTO_ICMP, 16'h0000,
           board_ip, dip};
    ich = {ICMP_ECHO_REPLY, 8'h00, 16'h0000, id, seq};
    for (int i = 0; i < PREAMBLE_LEN - 1; i++) begin
        f.push_back(PREAMBLE_BYTE);
    end
    f.push_back(SFD_BYTE);
    for (int i = 5; i >= 0; i--) begin
        f.push_back(dmac[8 * i +: 8]);
    end
    for (int i = 5; i >= 0; i--) begin
        f.push_back(board_mac[8 * i +: 8]);
    end
    f.push_back(ETH_TYPE_IPV4[15:8]);
    f.push_back(ETH_TYPE_IPV4[7:0]);
    for (int i = 19; i >= 0; i--) begin
        ip.push_back(iph[8 * i +: 8]);
    end
    c     = ones_csum(ip);
    ip[10] = c[15:8];
    ip[11] = c[7:0];
    for (int i = 7; i >= 0; i--) begin
        ic.push_back(ich[8 * i +: 8]);
    end
    foreach (pay[i]) ic.push_back(pay[i]);  // ICMP checksum covers the payload
    c     = ones_csum(ic);
    ic[2] = c[15:8];
    ic[3] = c[7:0];
    foreach (ip[i]) f.push_back(ip[i]);
    foreach (ic[i]) f.push_back(ic[i]);
    for (int i = pay.size(); i < MIN_PAYLOAD; i++) begin
        f.push_back(8'h00);
    end
    fcs = frame_crc(f, PREAMBLE_LEN);
    for (int i = 0; i < FCS_LEN; i++) begin
        f.push_back(fcs[8 * i +: 8]);       // Low byte leaves first
    end
    return f;
endfunction

`endif

// File: dv/icmp_reply_tx_tb.sv
// Testbench for the ICMP echo-reply transmitter with payload source, capture and compare
module icmp_reply_tx_tb import eth_pkg::*, icmp_pkg::*; ();

    localparam mac_addr_t board_mac     = 48'h02_00_5e_10_20_30;
    localparam ip_addr_t  board_ip      = {8'd10, 8'd0, 8'd0, 8'd7};
    localparam int        frame_timeout = 400;    // Cycles per wait loop

    logic        clk = 1'b0;
    logic        rst_n;
    logic        tx_start;
    mac_addr_t   dst_mac;
    ip_addr_t    dst_ip;
    logic [15:0] icmp_id;
    logic [15:0] icmp_seq;
    len_t        payload_len;
    csum_acc_t   payload_sum;
    logic        payload_req;
    byte_t       payload_data;
    logic        busy;
    logic        tx_done;
    logic        gmii_tx_en;
    byte_t       gmii_txd;

    `include "icmp_ref.svh"

    integer      seed = 27579;
    int          cyc = 0;
    int          start_cyc = 0;
    int          frames_done = 0;
    int          en_rises = 0;
    int          req_cnt = 0;
    int          req_runs = 0;
    int          src_idx = 0;
    int          exp_len = 0;
    int          err_cnt = 0;
    int          test_err0 = 0;
    int          tests_run = 0;
    int          tests_failed = 0;
    logic        prev_en = 1'b0;
    logic        prev_req = 1'b0;
    logic        prev_busy = 1'b0;
    logic        prev_done = 1'b0;
    logic        req_last = 1'b0;
    logic [15:0] next_ident;
    logic [15:0] last_ident;
    csum_t       last_csum;
    byte_q_t     src_q;
    byte_q_t     exp_q;
    byte_q_t     cap_q;

    icmp_reply_tx #(.board_mac(board_mac), .board_ip(board_ip)) dut0 (
        .clk          (clk),
        .rst_n        (rst_n),
        .tx_start     (tx_start),
        .dst_mac      (dst_mac),
        .dst_ip       (dst_ip),
        .icmp_id      (icmp_id),
        .icmp_seq     (icmp_seq),
        .payload_len  (payload_len),
        .payload_sum  (payload_sum),
        .payload_req  (payload_req),
        .payload_data (payload_data),
        .busy         (busy),
        .tx_done      (tx_done),
        .gmii_tx_en   (gmii_tx_en),
        .gmii_txd     (gmii_txd)
    );

    always #4 clk = ~clk;
    always @(posedge clk) cyc <= cyc + 1;

    // Payload source answering one cycle after each request
    always @(negedge clk) begin
        if (req_last && src_idx < src_q.size()) begin
            payload_data = src_q[src_idx];
            src_idx++;
        end else begin
            payload_data = 8'h00;
        end
        req_last = payload_req;
    end

    task automatic check_frame();
        if (cap_q.size() != exp_q.size()) begin
            $display("error frame length: got %h expected %h", cap_q.size(), exp_q.size());
            err_cnt++;
        end
        for (int i = 0; i < cap_q.size() && i < exp_q.size(); i++) begin
            if (cap_q[i] !== exp_q[i]) begin
                $display("error gmii_txd byte %0d: got %h expected %h", i, cap_q[i], exp_q[i]);
                err_cnt++;
            end
        end
        if (req_cnt != exp_len) begin
            $display("error payload_req cycles: got %h expected %h", req_cnt, exp_len);
            err_cnt++;
        end
        if (req_runs != 1) begin
            $display("payload_req was not one unbroken run");
            err_cnt++;
        end
        if (cap_q.size() > 33) begin
            last_ident = {cap_q[26], cap_q[27]};    // IP identification field
            last_csum  = {cap_q[32], cap_q[33]};
        end
    endtask

    // ----------------------------------------
    // Capture and compare
    // ----------------------------------------
    always @(negedge clk) begin
        if (rst_n) begin
            if (cyc == start_cyc && !busy) begin
                $display("busy did not rise on the cycle after the accepted start");
                err_cnt++;
            end
            if (gmii_tx_en && !prev_en) begin
                cap_q.delete();
                req_cnt  = 0;
                req_runs = 0;
                en_rises++;
                if (cyc != start_cyc + 6) begin
                    $display("error gmii_tx_en delay: got %h expected %h", cyc - start_cyc, 6);
                    err_cnt++;
                end
            end
            if (gmii_tx_en) begin
                cap_q.push_back(gmii_txd);
            end
            if (payload_req) begin
                req_cnt++;
                if (!prev_req) begin
                    req_runs++;
                end
            end
            if (tx_done) begin
                if (prev_done || !prev_en || gmii_tx_en) begin
                    $display("tx_done did not pulse once right after the last FCS byte");
                    err_cnt++;
                end
                if (!prev_busy || busy) begin
                    $display("busy did not fall together with tx_done");
                    err_cnt++;
                end
                check_frame();
                frames_done++;
            end
            prev_en   = gmii_tx_en;
            prev_req  = payload_req;
            prev_busy = busy;
            prev_done = tx_done;
        end
    end

    task automatic abort_run(input string why);
        err_cnt++;
        $display("timeout: %s", why);
        $display("ERRORS FOUND");
        $finish;
    endtask

    task automatic start_frame(input mac_addr_t m, input ip_addr_t ip, input logic [15:0] id,
                               input logic [15:0] seq, input int len);
        csum_acc_t sum;
        int        n;
        src_q.delete();
        sum = '0;
        for (int i = 0; i < len; i++) begin
            src_q.push_back(byte_t'($random(seed)));
        end
        for (int i = 0; i < len; i += 2) begin
            sum = sum + {16'h0000, src_q[i], (i + 1 < len) ? src_q[i + 1] : 8'h00};
        end
        exp_q      = expected_frame(m, ip, id, seq, next_ident, src_q);
        exp_len    = len;
        next_ident = next_ident + 16'd1;
        n = 0;
        @(negedge clk);
        while (busy && n < frame_timeout) begin
            @(negedge clk);
            n++;
        end
        if (busy) begin
            abort_run("busy stayed high before a new request");
        end
        src_idx     = 0;
        tx_start    = 1'b1;
        dst_mac     = m;
        dst_ip      = ip;
        icmp_id     = id;
        icmp_seq    = seq;
        payload_len = len_t'(len);
        payload_sum = sum;
        start_cyc   = cyc + 1;              // Count after the accepting edge
        @(negedge clk);
        tx_start = 1'b0;
    endtask

    task automatic wait_frames(input int target);
        int n;
        n = 0;
        while (frames_done < target && n < frame_timeout) begin
            @(negedge clk);
            n++;
        end
        if (frames_done < target) begin
            abort_run("no tx_done within the frame limit");
        end
    endtask

    task automatic end_test(input int num, input string name);
        tests_run++;
        if (err_cnt == test_err0) begin
            $display("test %0d %s: pass", num, name);
        end else begin
            tests_failed++;
            $display("test %0d %s: fail", num, name);
        end
        test_err0 = err_cnt;
    endtask

    initial begin
        int          n;
        int          len;
        mac_addr_t   m;
        logic [15:0] id_a;
        csum_t       cs_a;
        rst_n        = 1'b0;
        tx_start     = 1'b0;
        dst_mac      = '0;
        dst_ip       = '0;
        icmp_id      = '0;
        icmp_seq     = '0;
        payload_len  = '0;
        payload_sum  = '0;
        payload_data = '0;
        next_ident   = 16'd1;
        repeat (8) @(negedge clk);
        if (busy || tx_done || gmii_tx_en || payload_req || gmii_txd != '0) begin
            $display("outputs were not zero during reset");
            err_cnt++;
        end
        rst_n = 1'b1;

        start_frame(48'h3c_97_0e_a1_b2_c3, {8'd10, 8'd0, 8'd0, 8'd1}, 16'h1234, 16'h0001, 18);
        wait_frames(1);
        end_test(1, "18-byte payload frame");

        start_frame(48'h3c_97_0e_a1_b2_c3, {8'd10, 8'd0, 8'd0, 8'd1}, 16'h1234, 16'h0002, 5);
        wait_frames(2);
        end_test(2, "5-byte payload with padding");

        // Same addresses twice so the IP header differs only in the identification
        start_frame(48'h00_1b_21_aa_bb_cc, {8'd10, 8'd0, 8'd0, 8'd2}, 16'h0042, 16'h0010, 8);
        wait_frames(3);
        id_a = last_ident;
        cs_a = last_csum;
        start_frame(48'h00_1b_21_aa_bb_cc, {8'd10, 8'd0, 8'd0, 8'd2}, 16'h0042, 16'h0010, 8);
        wait_frames(4);
        if (last_ident != id_a + 16'd1) begin
            $display("error ip identification: got %h expected %h", last_ident, id_a + 16'd1);
            err_cnt++;
        end
        if (last_csum == cs_a) begin
            $display("IP header checksum did not change with the identification");
            err_cnt++;
        end
        end_test(3, "IP identification sequence");

        start_frame(48'h00_1b_21_aa_bb_cc, {8'd10, 8'd0, 8'd0, 8'd3}, 16'h0043, 16'h0011, 30);
        @(negedge clk);
        tx_start    = 1'b1;                 // Header still being built
        payload_len = 16'd9;
        @(negedge clk);
        tx_start = 1'b0;
        n = 0;
        while (!gmii_tx_en && n < frame_timeout) begin
            @(negedge clk);
            n++;
        end
        if (!gmii_tx_en) begin
            abort_run("gmii_tx_en never rose");
        end
        tx_start    = 1'b1;                 // Frame already on the line
        payload_len = 16'd9;
        @(negedge clk);
        tx_start = 1'b0;
        wait_frames(5);
        repeat (20) @(negedge clk);
        if (en_rises != 5 || busy) begin
            $display("a start while busy produced an extra frame");
            err_cnt++;
        end
        end_test(4, "start ignored while busy");

        for (int k = 0; k < 10; k++) begin
            m   = {16'($random(seed)), 32'($random(seed))};
            len = 1 + int'($unsigned($random(seed)) % 64);
            start_frame(m, ip_addr_t'($random(seed)), 16'($random(seed)), 16'($random(seed)), len);
            wait_frames(6 + k);
        end
        end_test(5, "ten random back-to-back frames");

        $display("%0d tests, %0d failed, %0d errors", tests_run, tests_failed, err_cnt);
        if (err_cnt == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule

// File: list.f
+incdir+dv
src/eth_pkg.sv
src/icmp_pkg.sv
src/icmp_hdr_if.sv
src/eth_crc32.sv
src/icmp_hdr_build.sv
src/eth_frame_tx.sv
src/icmp_reply_tx.sv
dv/icmp_reply_tx_tb.sv

// File: Makefile
VERILATOR ?= verilator
VFLAGS    = --binary --timing --assert
TOP       = icmp_reply_tx_tb
FILELIST  = list.f
OBJ_DIR   = obj_dir
LOG       = sim.log

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: compile
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -q "^NO ERRORS$$" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
